// ==== Bender.yml ====
package:
  name: msx_cart

sources:
  - include_dirs:
      - hw
    files:
      - hw/msx_cart_pkg.sv
      - hw/bus_phase_seq.sv
      - hw/bus_capture.sv
      - hw/sector_buffer.sv
      - hw/sdc_regs.sv
      - hw/cart_bus_io.sv
      - hw/msx_cart_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/msx_cart_assert.sv
      - tests/msx_cart_tb.sv

// ==== build.f ====
+incdir+hw
hw/msx_cart_pkg.sv
hw/bus_phase_seq.sv
hw/bus_capture.sv
hw/sector_buffer.sv
hw/sdc_regs.sv
hw/cart_bus_io.sv
hw/msx_cart_top.sv
tests/msx_cart_assert.sv
tests/msx_cart_tb.sv

// ==== hw/bus_capture.sv ====
`default_nettype none

`include "msx_cart_settings.svh"

module bus_capture (
    input  wire logic                clk108_w,
    input  wire logic                ram_enabled_w,
    input  wire logic                dot_ena,
    input  wire msx_cart_pkg::msel_t msel_n,
    input  wire msx_cart_pkg::byte_t mp,
    input  wire msx_cart_pkg::byte_t cd_pin,
    input  wire logic                rd_n_pin,
    input  wire logic                wr_n_pin,
    input  wire logic                sltsl_n_pin,
    output msx_cart_pkg::addr_t      addr,
    output msx_cart_pkg::byte_t      cdin,
    output logic                     merq_n,
    output logic                     iorq_n,
    output logic                     m1_n,
    output logic                     rd_n,
    output logic                     wr_n,
    output logic                     sltsl_n
);
    import msx_cart_pkg::*;

    localparam int SYNC_W = 2 * `MSX_DATA_W + 3;

    logic [SYNC_W-1:0] sync1_q;
    logic [SYNC_W-1:0] sync2_q;
    byte_t             mp_s;
    byte_t             cd_s;
    logic              rd_n_s;
    logic              wr_n_s;
    logic              sltsl_n_s;
    logic [2:0]        grp_d1;
    logic [2:0]        grp_d2;
    byte_t             addr_lo_q;
    byte_t             addr_hi_q;

    ////////////////////////////////////////
    // pin synchronizers
    ////////////////////////////////////////

    always_ff @(posedge clk108_w) begin
        sync1_q <= {sltsl_n_pin, wr_n_pin, rd_n_pin, cd_pin, mp};
        sync2_q <= sync1_q;
    end

    assign {sltsl_n_s, wr_n_s, rd_n_s, cd_s, mp_s} = sync2_q;

    // slot strobes delayed to line up with the synchronized mux byte
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            grp_d1 <= '0;
            grp_d2 <= '0;
        end else begin
            grp_d1 <= ~msel_n & {3{dot_ena}};
            grp_d2 <= grp_d1;
        end
    end

    ////////////////////////////////////////
    // latches
    ////////////////////////////////////////

    always_ff @(posedge clk108_w) begin
        if (grp_d2[0]) addr_lo_q <= mp_s;
        if (grp_d2[1]) addr_hi_q <= mp_s;
        if (grp_d2[2]) begin
            addr <= {addr_hi_q, addr_lo_q};     // whole address moves with the control byte
            if (sltsl_n_s || rd_n_s) cdin <= cd_s; // skip while we drive cd
        end
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            merq_n  <= 1'b1;
            iorq_n  <= 1'b1;
            m1_n    <= 1'b1;
            rd_n    <= 1'b1;
            wr_n    <= 1'b1;
            sltsl_n <= 1'b1;
        end else if (grp_d2[2]) begin
            merq_n  <= mp_s[0];
            iorq_n  <= mp_s[1];
            m1_n    <= mp_s[7];
            rd_n    <= rd_n_s;
            wr_n    <= wr_n_s;
            sltsl_n <= sltsl_n_s;
        end
    end

endmodule

`default_nettype wire

// ==== hw/bus_phase_seq.sv ====
`default_nettype none

`include "msx_cart_settings.svh"

module bus_phase_seq (
    input  wire logic           clk108_w,
    input  wire logic           ram_enabled_w,
    output msx_cart_pkg::msel_t msel_n,
    output logic                dot_ena
);
    import msx_cart_pkg::*;

    phase_t phase_q;

    // free running, wraps every 8 clocks
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + `PHASE_W'(1);
        end
    end

    ////////////////////////////////////////
    // select pattern, two clocks per slot
    ////////////////////////////////////////

    // upper bits pick the slot, bit 0 marks its second half
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            msel_n  <= 3'b111;
            dot_ena <= 1'b0;
        end else begin
            dot_ena <= phase_q[0] && (phase_q[`PHASE_W-1:1] != 2'b11); // none in idle slot
            case (phase_q[`PHASE_W-1:1])
                2'b00:   msel_n <= 3'b110;  // a0-a7
                2'b01:   msel_n <= 3'b101;  // a8-a15
                2'b10:   msel_n <= 3'b011;  // merq, iorq, m1
                default: msel_n <= 3'b111;  // idle
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/cart_bus_io.sv ====
`default_nettype none

`include "msx_cart_settings.svh"

module cart_bus_io (
    input  wire logic                clk108_w,
    input  wire logic                ram_enabled_w,
    input  wire msx_cart_pkg::addr_t addr,
    input  wire msx_cart_pkg::byte_t cdin,
    input  wire logic                iorq_n,
    input  wire logic                m1_n,
    input  wire logic                rd_n,
    input  wire logic                wr_n,
    input  wire logic                sltsl_n,
    input  wire msx_cart_pkg::byte_t rd_data,
    input  wire logic                rd_claim,
    output msx_cart_pkg::byte_t      cd_out,
    output logic                     datadir,
    output msx_cart_pkg::mapper_type_e mapper_type,
    output logic                     scc_enable
);
    import msx_cart_pkg::*;

    logic port_wr;

    ////////////////////////////////////////
    // mapper config port
    ////////////////////////////////////////

    // i/o cycles ignore the slot select
    assign port_wr = ~iorq_n & m1_n & ~wr_n & rd_n
                   & (addr[`MSX_ADDR_W/2-1:0] == `MEGARAM_PORT);

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            mapper_type <= KONAMI;
            scc_enable  <= 1'b0;
        end else if (port_wr) begin
            scc_enable <= 1'b0;
            case (cdin)
                8'h05: begin
                    mapper_type <= KONAMI_SCC;
                    scc_enable  <= 1'b1;
                end
                8'h16:   mapper_type <= ASCII16;
                8'h08:   mapper_type <= ASCII8;
                default: mapper_type <= KONAMI;
            endcase
        end
    end

    ////////////////////////////////////////
    // data bus out
    ////////////////////////////////////////

    always_ff @(posedge clk108_w) begin
        cd_out <= rd_claim ? rd_data : 8'hFF;  // unclaimed read floats high
    end

    // drive only for a read in our slot
    assign datadir = ~(~sltsl_n & ~rd_n);

endmodule

`default_nettype wire

// ==== hw/msx_cart_pkg.sv ====
`default_nettype none

package msx_cart_pkg;

    ////////////////////////////////////////
    // bus vectors
    ////////////////////////////////////////

    typedef logic [15:0] addr_t;        // cpu address
    typedef logic [7:0]  byte_t;        // data or mux byte

    // sd side
    typedef logic [31:0] sector_t;
    typedef logic [8:0]  buf_addr_t;    // offset in 512 byte sector

    // external mux, active low, one slot at a time
    typedef logic [2:0]  msel_t;
    typedef logic [2:0]  phase_t;

    ////////////////////////////////////////
    // mapper selection
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        KONAMI     = 2'd0,
        KONAMI_SCC = 2'd1,
        ASCII16    = 2'd2,
        ASCII8     = 2'd3
    } mapper_type_e;

endpackage

`default_nettype wire

// ==== hw/msx_cart_settings.svh ====
`ifndef MSX_CART_SETTINGS_SVH
`define MSX_CART_SETTINGS_SVH

////////////////////////////////////////
// cartridge bus
////////////////////////////////////////

`define MSX_ADDR_W          16
`define MSX_DATA_W          8

////////////////////////////////////////
// sd controller window in the bios slot
////////////////////////////////////////

`define SDC_SDATA           16'h7C00    // sector buffer, 512 bytes
`define SDC_ENABLE          16'h7E00
`define SDC_CMD             16'h7E01
`define SDC_STATUS          16'h7E02
`define SDC_SADDR           16'h7E03    // 4 bytes, lsb first
`define SDC_CTYPE           16'h7E0F
`define SDC_END             16'h7EFF

// mapper config i/o port
`define MEGARAM_PORT        8'h8F

`define SECTOR_BYTES_LOG2   9
`define PHASE_W             3           // 8 clocks per bus phase

`endif

// ==== hw/msx_cart_top.sv ====
`default_nettype none

`include "msx_cart_settings.svh"

module msx_cart_top (
    input  wire logic                    clk108_w,
    input  wire logic                    ram_enabled_w,
    // cartridge pins
    input  wire msx_cart_pkg::byte_t     mp,
    input  wire logic                    rd_n,
    input  wire logic                    wr_n,
    input  wire logic                    sltsl_n,
    inout  wire msx_cart_pkg::byte_t     cd,
    output msx_cart_pkg::msel_t          msel_n,
    output logic                         datadir,
    output logic                         led,
    output msx_cart_pkg::mapper_type_e   mapper_type,
    output logic                         scc_enable,
    // card side
    input  wire logic                    sd_busy,
    input  wire logic                    sd_done,
    input  wire logic                    sd_outen,
    input  wire msx_cart_pkg::buf_addr_t sd_outaddr,
    input  wire msx_cart_pkg::byte_t     sd_outbyte,
    input  wire logic [1:0]              card_type,
    input  wire logic                    crc_error,
    input  wire logic                    timeout_error,
    output logic                         sd_rstart,
    output logic                         sd_wstart,
    output logic                         sd_init,
    output msx_cart_pkg::sector_t        sd_sector,
    output msx_cart_pkg::byte_t          sd_inbyte
);
    import msx_cart_pkg::*;

    logic  dot_ena;
    addr_t addr;
    byte_t cdin;
    logic  merq_n;
    logic  iorq_n;
    logic  m1_n;
    logic  bus_rd_n;        // latched copies of the pins
    logic  bus_wr_n;
    logic  bus_sltsl_n;
    byte_t rd_data;
    logic  rd_claim;
    byte_t cd_out;

    bus_phase_seq bus_phase_seq_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .msel_n        (msel_n),
        .dot_ena       (dot_ena)
    );

    bus_capture bus_capture_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .dot_ena       (dot_ena),
        .msel_n        (msel_n),
        .mp            (mp),
        .cd_pin        (cd),
        .rd_n_pin      (rd_n),
        .wr_n_pin      (wr_n),
        .sltsl_n_pin   (sltsl_n),
        .addr          (addr),
        .cdin          (cdin),
        .merq_n        (merq_n),
        .iorq_n        (iorq_n),
        .m1_n          (m1_n),
        .rd_n          (bus_rd_n),
        .wr_n          (bus_wr_n),
        .sltsl_n       (bus_sltsl_n)
    );

    sdc_regs sdc_regs_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .addr          (addr),
        .cdin          (cdin),
        .merq_n        (merq_n),
        .iorq_n        (iorq_n),
        .m1_n          (m1_n),
        .rd_n          (bus_rd_n),
        .wr_n          (bus_wr_n),
        .sltsl_n       (bus_sltsl_n),
        .sd_busy       (sd_busy),
        .sd_done       (sd_done),
        .sd_outen      (sd_outen),
        .sd_outaddr    (sd_outaddr),
        .sd_outbyte    (sd_outbyte),
        .card_type     (card_type),
        .crc_error     (crc_error),
        .timeout_error (timeout_error),
        .rd_data       (rd_data),
        .rd_claim      (rd_claim),
        .sd_rstart     (sd_rstart),
        .sd_wstart     (sd_wstart),
        .sd_init       (sd_init),
        .sd_sector     (sd_sector),
        .sd_inbyte     (sd_inbyte),
        .led           (led)
    );

    cart_bus_io cart_bus_io_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .addr          (addr),
        .cdin          (cdin),
        .iorq_n        (iorq_n),
        .m1_n          (m1_n),
        .rd_n          (bus_rd_n),
        .wr_n          (bus_wr_n),
        .sltsl_n       (bus_sltsl_n),
        .rd_data       (rd_data),
        .rd_claim      (rd_claim),
        .cd_out        (cd_out),
        .datadir       (datadir),
        .mapper_type   (mapper_type),
        .scc_enable    (scc_enable)
    );

    // low datadir turns the level shifter toward the cpu
    assign cd = datadir ? 'z : cd_out;

endmodule

`default_nettype wire

// ==== hw/sdc_regs.sv ====
`default_nettype none

`include "msx_cart_settings.svh"

module sdc_regs (
    input  wire logic                    clk108_w,
    input  wire logic                    ram_enabled_w,
    input  wire msx_cart_pkg::addr_t     addr,
    input  wire msx_cart_pkg::byte_t     cdin,
    input  wire logic                    merq_n,
    input  wire logic                    iorq_n,
    input  wire logic                    m1_n,
    input  wire logic                    rd_n,
    input  wire logic                    wr_n,
    input  wire logic                    sltsl_n,
    input  wire logic                    sd_busy,
    input  wire logic                    sd_done,
    input  wire logic                    sd_outen,
    input  wire msx_cart_pkg::buf_addr_t sd_outaddr,
    input  wire msx_cart_pkg::byte_t     sd_outbyte,
    input  wire logic [1:0]              card_type,
    input  wire logic                    crc_error,
    input  wire logic                    timeout_error,
    output msx_cart_pkg::byte_t          rd_data,
    output logic                         rd_claim,
    output logic                         sd_rstart,
    output logic                         sd_wstart,
    output logic                         sd_init,
    output msx_cart_pkg::sector_t        sd_sector,
    output msx_cart_pkg::byte_t          sd_inbyte,
    output logic                         led
);
    import msx_cart_pkg::*;

    logic  mem_cyc;
    logic  buf_win;
    logic  reg_win;
    logic  en_wr;
    logic  reg_wr;
    logic  sd_en;
    logic  buf_sel_q;
    logic  card_rd_q;
    byte_t rd_reg_q;
    byte_t a_dout;
    byte_t b_dout;

    ////////////////////////////////////////
    // window decode
    ////////////////////////////////////////

    assign mem_cyc = ~merq_n & iorq_n & m1_n & ~sltsl_n;
    assign en_wr   = mem_cyc & ~wr_n & (addr == `SDC_ENABLE);   // works while disabled too
    assign buf_win = sd_en & mem_cyc & (addr >= `SDC_SDATA) & (addr < `SDC_ENABLE);
    assign reg_win = sd_en & mem_cyc & (addr >= `SDC_ENABLE) & (addr <= `SDC_END);
    assign reg_wr  = reg_win & ~wr_n;

    sector_buffer sector_buffer_i (
        .clk108_w (clk108_w),
        .a_we     (buf_win & ~wr_n),
        .a_addr   (addr[`SECTOR_BYTES_LOG2-1:0]),
        .a_din    (cdin),
        .a_dout   (a_dout),
        .b_we     (sd_rstart & sd_outen),      // card fills buffer on a read
        .b_addr   (sd_outaddr),
        .b_din    (sd_outbyte),
        .b_dout   (b_dout)
    );

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            sd_en     <= 1'b0;
            sd_rstart <= 1'b0;
            sd_wstart <= 1'b0;
            sd_init   <= 1'b0;
        end else begin
            if (en_wr) sd_en <= cdin[0];
            if (sd_done) begin
                sd_rstart <= 1'b0;
                sd_wstart <= 1'b0;
            end else if (reg_wr && addr == `SDC_CMD) begin
                sd_rstart <= sd_rstart | cdin[0];
                sd_wstart <= sd_wstart | cdin[1];
            end
            if (reg_wr && addr == `SDC_CMD) sd_init <= sd_init | cdin[7];
        end
    end

    // sector number, lsb at the lowest address
    always_ff @(posedge clk108_w) begin
        if (reg_wr) begin
            case (addr)
                `SDC_SADDR:          sd_sector[7:0]   <= cdin;
                `SDC_SADDR + 16'd1:  sd_sector[15:8]  <= cdin;
                `SDC_SADDR + 16'd2:  sd_sector[23:16] <= cdin;
                `SDC_SADDR + 16'd3:  sd_sector[31:24] <= cdin;
                default:             ;
            endcase
        end
    end

    ////////////////////////////////////////
    // cpu read path
    ////////////////////////////////////////

    always_ff @(posedge clk108_w) begin
        case (addr)
            `SDC_ENABLE: rd_reg_q <= {7'b0, sd_en};
            `SDC_STATUS: rd_reg_q <= {sd_busy, 5'b0, timeout_error, crc_error};
            `SDC_CTYPE:  rd_reg_q <= {6'b0, card_type};
            default:     rd_reg_q <= 8'hFF;    // csd/cid range included
        endcase
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            rd_claim  <= 1'b0;
            buf_sel_q <= 1'b0;
            card_rd_q <= 1'b0;
        end else begin
            rd_claim  <= (reg_win | buf_win) & ~rd_n;
            buf_sel_q <= buf_win & ~rd_n;
            card_rd_q <= sd_wstart;
        end
    end

    assign rd_data   = buf_sel_q ? a_dout : rd_reg_q;
    assign sd_inbyte = card_rd_q ? b_dout : 8'hFF;  // card sees data only during a write
    assign led       = sd_busy;

endmodule

`default_nettype wire

// ==== hw/sector_buffer.sv ====
`default_nettype none

`include "msx_cart_settings.svh"

module sector_buffer (
    input  wire logic                    clk108_w,
    // cpu window side
    input  wire logic                    a_we,
    input  wire msx_cart_pkg::buf_addr_t a_addr,
    input  wire msx_cart_pkg::byte_t     a_din,
    output msx_cart_pkg::byte_t          a_dout,
    // card side
    input  wire logic                    b_we,
    input  wire msx_cart_pkg::buf_addr_t b_addr,
    input  wire msx_cart_pkg::byte_t     b_din,
    output msx_cart_pkg::byte_t          b_dout
);
    import msx_cart_pkg::*;

    localparam int DEPTH = 1 << `SECTOR_BYTES_LOG2;

    byte_t mem [DEPTH];

    // card port wins a same address write
    always_ff @(posedge clk108_w) begin
        if (a_we) mem[a_addr] <= a_din;
        if (b_we) mem[b_addr] <= b_din;
        a_dout <= mem[a_addr];      // one cycle read
        b_dout <= mem[b_addr];
    end

endmodule

`default_nettype wire

// ==== tests/msx_cart_assert.sv ====
`default_nettype none

module msx_cart_assert (
    input wire logic                clk108_w,
    input wire logic                ram_enabled_w,
    input wire msx_cart_pkg::msel_t msel_n,
    input wire logic                datadir,
    input wire logic                bus_rd_n,
    input wire logic                sd_done,
    input wire logic                sd_rstart
);
    timeunit 1ns;
    timeprecision 100ps;

    // external mux enables one byte at a time
    mux_onehot_a: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        $onehot0(~msel_n))
        else $error("more than one mux select low: %b", msel_n);

    datadir_a: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        bus_rd_n |-> datadir)
        else $error("data bus turned toward the cpu without a read");

    rstart_clr_a: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        sd_done |=> !sd_rstart)
        else $error("sd_rstart still high after sd_done");   // card finished

endmodule

bind msx_cart_top msx_cart_assert msx_cart_assert_i (
    .clk108_w      (clk108_w),
    .ram_enabled_w (ram_enabled_w),
    .msel_n        (msel_n),
    .datadir       (datadir),
    .bus_rd_n      (bus_rd_n),
    .sd_done       (sd_done),
    .sd_rstart     (sd_rstart)
);

`default_nettype wire

// ==== tests/msx_cart_tb.sv ====
`default_nettype none

`include "msx_cart_settings.svh"

module msx_cart_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import msx_cart_pkg::*;

    localparam int    HOLD           = 6 * 8;   // six phase periods per bus state
    localparam int    TIMEOUT_CYCLES = 20000;   // 27 bus ops of 147 cycles, about 4000, with margin
    localparam byte_t IDLE_CTRL      = 8'hFF;
    localparam byte_t MEM_CTRL       = 8'hFE;   // merq_n low
    localparam byte_t IO_CTRL        = 8'hFD;   // iorq_n low

    logic         clk108_w;
    logic         ram_enabled_w;
    byte_t        mp;
    logic         rd_n;
    logic         wr_n;
    logic         sltsl_n;
    wire  [7:0]   cd;
    logic         sd_busy;
    logic         sd_done;
    logic         sd_outen;
    buf_addr_t    sd_outaddr;
    byte_t        sd_outbyte;
    logic [1:0]   card_type;
    logic         crc_error;
    logic         timeout_error;
    msel_t        msel_n;
    logic         datadir;
    logic         led;
    mapper_type_e mapper_type;
    logic         scc_enable;
    logic         sd_rstart;
    logic         sd_wstart;
    logic         sd_init;
    sector_t      sd_sector;
    byte_t        sd_inbyte;

    // cpu side bus state seen through the mux
    addr_t        bus_addr;
    byte_t        bus_ctrl;
    byte_t        cd_drv;
    string        cur_test;
    int           errors;
    int           test_start_errors;
    int           checks;
    int           cycle_cnt;

    msx_cart_top dut_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .sltsl_n       (sltsl_n),
        .cd            (cd),
        .msel_n        (msel_n),
        .datadir       (datadir),
        .led           (led),
        .mapper_type   (mapper_type),
        .scc_enable    (scc_enable),
        .sd_busy       (sd_busy),
        .sd_done       (sd_done),
        .sd_outen      (sd_outen),
        .sd_outaddr    (sd_outaddr),
        .sd_outbyte    (sd_outbyte),
        .card_type     (card_type),
        .crc_error     (crc_error),
        .timeout_error (timeout_error),
        .sd_rstart     (sd_rstart),
        .sd_wstart     (sd_wstart),
        .sd_init       (sd_init),
        .sd_sector     (sd_sector),
        .sd_inbyte     (sd_inbyte)
    );

    always #20 clk108_w = ~clk108_w;

    assign cd = cd_drv;

    // mux answers the select that the dut drives
    always @(posedge clk108_w) begin
        case (msel_n)
            3'b110:  mp <= bus_addr[7:0];
            3'b101:  mp <= bus_addr[15:8];
            3'b011:  mp <= bus_ctrl;
            default: mp <= 8'hFF;
        endcase
    end

    ////////////////////////////////////////
    // bookkeeping
    ////////////////////////////////////////

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch in test %s, %s: expected %0h, actual %0h",
                     cur_test, what, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Error in test %s: %s", cur_test, msg);
    endtask

    task automatic start_test(input string name);
        cur_test          = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        $display("test %s finished with %0d errors", cur_test, errors - test_start_errors);
    endtask

    ////////////////////////////////////////
    // cpu and card models
    ////////////////////////////////////////

    task automatic set_bus(input addr_t a, input byte_t ctrl, input logic rd, input logic wr,
                           input logic slt, input byte_t data);
        @(posedge clk108_w);
        bus_addr <= a;
        bus_ctrl <= ctrl;
        rd_n     <= rd;
        wr_n     <= wr;
        sltsl_n  <= slt;
        cd_drv   <= data;
        repeat (HOLD) @(posedge clk108_w);
    endtask

    task automatic cpu_mem_write(input addr_t a, input byte_t data);
        set_bus(a, IDLE_CTRL, 1'b1, 1'b1, 1'b1, data);  // address settles first
        set_bus(a, MEM_CTRL, 1'b1, 1'b0, 1'b0, data);
        set_bus(a, IDLE_CTRL, 1'b1, 1'b1, 1'b1, data);
    endtask

    task automatic cpu_mem_read(input addr_t a, output byte_t data);
        set_bus(a, IDLE_CTRL, 1'b1, 1'b1, 1'b1, 8'hzz);
        set_bus(a, MEM_CTRL, 1'b0, 1'b1, 1'b0, 8'hzz);
        @(negedge clk108_w);
        check("datadir in read", 0, datadir);
        data = cd;
        set_bus(a, IDLE_CTRL, 1'b1, 1'b1, 1'b1, 8'hzz); // keep cd released until turned around
    endtask

    task automatic io_write(input byte_t port, input byte_t data);
        set_bus({8'h00, port}, IDLE_CTRL, 1'b1, 1'b1, 1'b1, data);
        set_bus({8'h00, port}, IO_CTRL, 1'b1, 1'b0, 1'b1, data);
        set_bus({8'h00, port}, IDLE_CTRL, 1'b1, 1'b1, 1'b1, data);
    endtask

    task automatic card_write(input buf_addr_t off, input byte_t data);
        @(posedge clk108_w);
        sd_outen   <= 1'b1;
        sd_outaddr <= off;
        sd_outbyte <= data;
        @(posedge clk108_w);
        sd_outen   <= 1'b0;
    endtask

    task automatic card_read(input buf_addr_t off, output byte_t data);
        @(posedge clk108_w);
        sd_outaddr <= off;
        @(posedge clk108_w);                            // registered card port
        @(negedge clk108_w);
        data = sd_inbyte;
    endtask

    task automatic card_done();
        @(posedge clk108_w);
        sd_done <= 1'b1;
        @(posedge clk108_w);
        sd_done <= 1'b0;
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic phase_sequence();
        msel_t seq [4];
        msel_t prev;
        int    n;
        int    i;
        seq = '{3'b110, 3'b101, 3'b011, 3'b111};
        start_test("phase");
        n = 0;
        @(negedge clk108_w);
        check("datadir after reset", 1, datadir);
        check("mapper after reset", KONAMI, mapper_type);
        check("sd starts after reset", 0, {sd_rstart, sd_wstart, sd_init, scc_enable});
        prev = msel_n;
        @(negedge clk108_w);
        while (!(prev == 3'b111 && msel_n == 3'b110) && n < 16) begin
            prev = msel_n;
            @(negedge clk108_w);
            n++;
        end
        if (n >= 16) begin
            report_failure("mux select never entered the low address slot");
        end else begin
            for (i = 0; i < 16; i++) begin
                check("msel_n", seq[(i / 2) % 4], msel_n);  // two clocks per slot
                @(negedge clk108_w);
            end
        end
        end_test();
    endtask

    task automatic enable_and_direction();
        byte_t got;
        start_test("enable");
        set_bus(16'h0000, IDLE_CTRL, 1'b1, 1'b1, 1'b0, 8'hzz);
        @(negedge clk108_w);
        check("datadir, rd_n high", 1, datadir);
        check("cd released, rd_n high", 32'h0000_00zz, {24'h0, cd});
        set_bus(16'h0000, IDLE_CTRL, 1'b0, 1'b1, 1'b1, 8'hzz);
        @(negedge clk108_w);
        check("datadir, sltsl_n high", 1, datadir);
        check("cd released, sltsl_n high", 32'h0000_00zz, {24'h0, cd});
        cpu_mem_read(`SDC_ENABLE, got);
        check("enable before write", 8'hFF, got);
        cpu_mem_write(`SDC_ENABLE, 8'h01);
        cpu_mem_read(`SDC_ENABLE, got);
        check("enable after write", 8'h01, got);
        end_test();
    endtask

    task automatic status_step(input logic busy, input logic tmo, input logic crc,
                               input byte_t exp_status);
        byte_t got;
        @(posedge clk108_w);
        sd_busy       <= busy;
        timeout_error <= tmo;
        crc_error     <= crc;
        cpu_mem_read(`SDC_STATUS, got);
        check("status", exp_status, got);
        check("led", busy, led);
    endtask

    task automatic sector_and_command();
        byte_t sec_b [4];
        byte_t got;
        int    i;
        sec_b = '{8'h4D, 8'h3C, 8'h2B, 8'h1A};       // lsb first
        start_test("sector");
        for (i = 0; i < 4; i++) begin
            cpu_mem_write(addr_t'(`SDC_SADDR + i), sec_b[i]);
        end
        cpu_mem_write(`SDC_CMD, 8'h01);
        @(negedge clk108_w);
        check("sd_sector", 32'h1A2B_3C4D, sd_sector);
        check("sd_rstart set", 1, sd_rstart);
        card_done();
        @(negedge clk108_w);
        check("sd_rstart after done", 0, sd_rstart);
        cpu_mem_write(`SDC_CMD, 8'h80);
        @(negedge clk108_w);
        check("sd_init set", 1, sd_init);
        check("sd_rstart with init only", 0, sd_rstart);
        status_step(1'b1, 1'b1, 1'b0, 8'h82);
        status_step(1'b0, 1'b0, 1'b1, 8'h01);
        @(posedge clk108_w);
        card_type <= 2'b10;
        cpu_mem_read(`SDC_CTYPE, got);
        check("card type", 8'h02, got);
        cpu_mem_read(16'h7E20, got);                 // dropped csd/cid field
        check("csd/cid byte", 8'hFF, got);
        end_test();
    endtask

    task automatic buffer_card_to_cpu();
        buf_addr_t offs [4];
        byte_t     data [4];
        byte_t     got;
        int        i;
        offs = '{9'd0, 9'd37, 9'd256, 9'd511};
        start_test("card2cpu");
        for (i = 0; i < 4; i++) begin
            data[i] = byte_t'($urandom());
        end
        cpu_mem_write(`SDC_CMD, 8'h01);
        @(negedge clk108_w);
        check("sd_rstart set", 1, sd_rstart);
        for (i = 0; i < 4; i++) begin
            card_write(offs[i], data[i]);
        end
        card_done();
        for (i = 0; i < 4; i++) begin
            cpu_mem_read(`SDC_SDATA + offs[i], got);
            check("buffer byte", data[i], got);
        end
        end_test();
    endtask

    task automatic buffer_cpu_to_card();
        buf_addr_t offs [4];
        byte_t     data [4];
        byte_t     got;
        int        i;
        offs = '{9'd3, 9'd64, 9'd300, 9'd508};
        start_test("cpu2card");
        for (i = 0; i < 4; i++) begin
            data[i] = byte_t'($urandom());
            cpu_mem_write(`SDC_SDATA + offs[i], data[i]);
        end
        cpu_mem_write(`SDC_CMD, 8'h02);
        @(negedge clk108_w);
        check("sd_wstart set", 1, sd_wstart);
        for (i = 0; i < 4; i++) begin
            card_read(offs[i], got);
            check("sd_inbyte", data[i], got);
        end
        card_done();
        end_test();
    endtask

    task automatic mapper_step(input byte_t val, input mapper_type_e exp_type,
                               input logic exp_scc);
        io_write(`MEGARAM_PORT, val);
        @(negedge clk108_w);
        check("mapper_type", exp_type, mapper_type);
        check("scc_enable", exp_scc, scc_enable);
    endtask

    task automatic mapper_config();
        start_test("mapper");
        mapper_step(8'h05, KONAMI_SCC, 1'b1);
        mapper_step(8'h16, ASCII16, 1'b0);
        mapper_step(8'h08, ASCII8, 1'b0);
        mapper_step(8'h33, KONAMI, 1'b0);            // any other value
        end_test();
    endtask

    ////////////////////////////////////////
    // run control
    ////////////////////////////////////////

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk108_w);
            cycle_cnt++;
        end
        $display("Timeout: run stopped after %0d cycles without finishing", cycle_cnt);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h9628_8420));
        errors        = 0;
        checks        = 0;
        clk108_w      = 1'b0;
        ram_enabled_w = 1'b0;
        mp            = 8'hFF;
        rd_n          = 1'b1;
        wr_n          = 1'b1;
        sltsl_n       = 1'b1;
        cd_drv        = 8'hFF;
        bus_addr      = '0;
        bus_ctrl      = IDLE_CTRL;
        sd_busy       = 1'b0;
        sd_done       = 1'b0;
        sd_outen      = 1'b0;
        sd_outaddr    = '0;
        sd_outbyte    = '0;
        card_type     = 2'b00;
        crc_error     = 1'b0;
        timeout_error = 1'b0;
        repeat (3) @(posedge clk108_w);
        ram_enabled_w <= 1'b1;
        phase_sequence();
        enable_and_direction();
        sector_and_command();
        buffer_card_to_cpu();
        buffer_cpu_to_card();
        mapper_config();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
